/* include/csr_index_settings.svh */
`ifndef CSR_INDEX_SETTINGS_SVH
`define CSR_INDEX_SETTINGS_SVH

// --------------------
// Datapath widths
// --------------------

// Edge-array index, offset and degree width
`define CSR_INDEX_DATA_W 32

// One-hot destination mask, one bit per lane
`define CSR_INDEX_MASK_W 8

// --------------------
// Config FIFO sizing
// --------------------

// Default number of range entries held between engine and generator
`define CSR_INDEX_FIFO_DEPTH 16

// Fill level where response_ready drops
// Leaves four free slots for the three engine stages plus one in flight
`define CSR_INDEX_ALMOST_FULL 12

`endif

/* src/csr_index_pkg.sv */
`include "csr_index_settings.svh"

package csr_index_pkg;

    // --------------------
    // Scalar words
    // --------------------

    // Index into the edge array, also used for offsets and range bounds
    typedef logic [`CSR_INDEX_DATA_W-1:0] csr_index_t;

    // Edge count of one vertex
    typedef logic [`CSR_INDEX_DATA_W-1:0] csr_degree_t;

    // One-hot lane select carried by each vertex response
    typedef logic [`CSR_INDEX_MASK_W-1:0] csr_module_mask_t;

    // --------------------
    // Range configuration
    // --------------------

    // Half-open range [index_start, index_end)
    // Flattened to a plain vector inside the config FIFO
    typedef struct packed {
        csr_index_t index_start;
        csr_index_t index_end;
    } csr_range_t;

    // --------------------
    // Generator FSM
    // --------------------

    // GEN_IDLE pops a range, GEN_LOAD sets up the walk, GEN_RUN emits indices
    typedef enum logic [1:0] {
        GEN_IDLE = 2'd0,
        GEN_LOAD = 2'd1,
        GEN_RUN  = 2'd2
    } gen_state_e;

endpackage : csr_index_pkg

/* src/csr_index_configure_engine.sv */
module csr_index_configure_engine #(
    parameter int module_id = 0
) (
    input  logic                             ap_clk,
    input  logic                             areset_csr_index_generator,
    input  logic                             response_valid,
    input  csr_index_pkg::csr_module_mask_t  response_destination,
    input  csr_index_pkg::csr_index_t        response_offset,
    input  csr_index_pkg::csr_degree_t       response_degree,
    input  logic                             almost_full,
    output logic                             response_ready,
    output logic                             push,
    output csr_index_pkg::csr_range_t        push_data
);

    import csr_index_pkg::*;

    // Mask value that addresses this lane
    localparam csr_module_mask_t module_mask = csr_module_mask_t'(1) << module_id;

    // Stage 1, raw input capture
    logic             in_valid_q;
    csr_module_mask_t in_destination_q;
    csr_index_t       in_offset_q;
    csr_degree_t      in_degree_q;

    // Destination compare on the captured response
    logic             in_match;

    // Stage 2, responses for this lane only
    logic             match_valid_q;
    csr_index_t       match_offset_q;
    csr_degree_t      match_degree_q;

    // Stage 3, finished range configuration
    logic             cfg_valid_q;
    csr_range_t       cfg_range_q;

    // --------------------
    // Input register
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= response_valid;
        end
    end

    // Payload only matters when the valid bit says so
    always_ff @(posedge ap_clk) begin
        in_destination_q <= response_destination;
        in_offset_q      <= response_offset;
        in_degree_q      <= response_degree;
    end

    // Exact compare, so multi-bit masks never match
    assign in_match = in_valid_q & (in_destination_q == module_mask);

    // --------------------
    // Filter register
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            match_valid_q <= 1'b0;
        end else begin
            match_valid_q <= in_match;
        end
    end

    always_ff @(posedge ap_clk) begin
        match_offset_q <= in_offset_q;
        match_degree_q <= in_degree_q;
    end

    // --------------------
    // Configuration register
    // --------------------

    // Zero-degree vertices have no edges to walk
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            cfg_valid_q <= 1'b0;
        end else begin
            cfg_valid_q <= match_valid_q & (|match_degree_q);
        end
    end

    // End bound is exclusive
    always_ff @(posedge ap_clk) begin
        cfg_range_q.index_start <= match_offset_q;
        cfg_range_q.index_end   <= match_offset_q + match_degree_q;
    end

    // --------------------
    // Outputs
    // --------------------

    assign push      = cfg_valid_q;
    assign push_data = cfg_range_q;

    // Credit style ready, upstream watches it one cycle late
    assign response_ready = ~almost_full;

endmodule : csr_index_configure_engine

/* src/csr_index_config_fifo.sv */
`include "csr_index_settings.svh"

module csr_index_config_fifo #(
    parameter int data_width        = 2 * `CSR_INDEX_DATA_W,
    parameter int depth             = `CSR_INDEX_FIFO_DEPTH,
    parameter int almost_full_level = `CSR_INDEX_ALMOST_FULL
) (
    input  logic                  ap_clk,
    input  logic                  areset_csr_index_generator,
    input  logic                  push,
    input  logic                  pop,
    input  logic [data_width-1:0] push_data,
    output logic [data_width-1:0] head_data,
    output logic                  not_empty,
    output logic                  almost_full
);

    // Pointer and fill counter widths
    localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    // Storage
    logic [data_width-1:0] mem [depth];

    logic [ptr_w-1:0]   wr_ptr_q;
    logic [ptr_w-1:0]   rd_ptr_q;
    logic [count_w-1:0] count_q;

    logic full;
    logic do_push;
    logic do_pop;

    // Wrap at depth, so depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        logic [ptr_w-1:0] result;
        if (ptr == ptr_w'(depth - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    // --------------------
    // Status
    // --------------------

    assign full        = (count_q == count_w'(depth));
    assign not_empty   = (count_q != '0);
    assign almost_full = (count_q >= count_w'(almost_full_level));

    // Guard against overflow and underflow
    assign do_push = push & ~full;
    assign do_pop  = pop & not_empty;

    // --------------------
    // Pointers and count
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    // First word falls through
    assign head_data = mem[rd_ptr_q];

endmodule : csr_index_config_fifo

/* src/csr_index_generator.sv */
module csr_index_generator (
    input  logic                       ap_clk,
    input  logic                       areset_csr_index_generator,
    input  logic                       not_empty,
    input  csr_index_pkg::csr_range_t  head_data,
    input  logic                       index_ready,
    output logic                       pop,
    output logic                       index_valid,
    output csr_index_pkg::csr_index_t  index_out,
    output logic                       index_last
);

    import csr_index_pkg::*;

    gen_state_e state_q;
    gen_state_e state_d;

    // Copy of the popped FIFO head
    csr_range_t range_q;

    // Running index and exclusive end bound
    csr_index_t index_q;
    csr_index_t end_q;
    csr_index_t index_next;

    // Handshake on the index stream
    logic       accept;

    // --------------------
    // Stream outputs
    // --------------------

    assign index_next  = index_q + 1'b1;
    assign index_valid = (state_q == GEN_RUN);
    assign index_out   = index_q;

    // Last when the following index would hit the end bound
    assign index_last = index_valid & (index_next == end_q);

    assign accept = index_valid & index_ready;

    // Pop only with data present, and only between ranges
    assign pop = (state_q == GEN_IDLE) & not_empty;

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            GEN_IDLE: begin
                if (not_empty) begin
                    state_d = GEN_LOAD;
                end
            end
            GEN_LOAD: begin
                state_d = GEN_RUN;
            end
            GEN_RUN: begin
                // Range done once its last index is taken
                if (accept && index_last) begin
                    state_d = GEN_IDLE;
                end
            end
            default: begin
                state_d = GEN_IDLE;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            state_q <= GEN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Range datapath
    // --------------------

    // Head leaves the FIFO on this edge, so keep a copy
    always_ff @(posedge ap_clk) begin
        if (pop) begin
            range_q <= head_data;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (state_q == GEN_LOAD) begin
            index_q <= range_q.index_start;
            end_q   <= range_q.index_end;
        end else if (accept) begin
            // Held while the sink stalls
            index_q <= index_next;
        end
    end

endmodule : csr_index_generator

/* src/csr_index_top.sv */
`include "csr_index_settings.svh"

module csr_index_top #(
    parameter int module_id = 0
) (
    input  logic                             ap_clk,
    input  logic                             areset_csr_index_generator,

    // Vertex responses
    input  logic                             response_valid,
    input  csr_index_pkg::csr_module_mask_t  response_destination,
    input  csr_index_pkg::csr_index_t        response_offset,
    input  csr_index_pkg::csr_degree_t       response_degree,
    output logic                             response_ready,

    // Index stream
    output logic                             index_valid,
    output csr_index_pkg::csr_index_t        index_out,
    output logic                             index_last,
    input  logic                             index_ready
);

    import csr_index_pkg::*;

    // Engine to FIFO
    logic       push;
    csr_range_t push_data;
    logic       almost_full;

    // FIFO to generator
    logic       not_empty;
    csr_range_t head_data;
    logic       pop;

    // --------------------
    // Response filter and range builder
    // --------------------

    csr_index_configure_engine #(
        .module_id (module_id)
    ) u_configure_engine (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_destination       (response_destination),
        .response_offset            (response_offset),
        .response_degree            (response_degree),
        .almost_full                (almost_full),
        .response_ready             (response_ready),
        .push                       (push),
        .push_data                  (push_data)
    );

    // --------------------
    // Range buffer
    // --------------------

    csr_index_config_fifo #(
        .data_width        ($bits(csr_range_t)),
        .depth             (`CSR_INDEX_FIFO_DEPTH),
        .almost_full_level (`CSR_INDEX_ALMOST_FULL)
    ) u_config_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .push                       (push),
        .pop                        (pop),
        .push_data                  (push_data),
        .head_data                  (head_data),
        .not_empty                  (not_empty),
        .almost_full                (almost_full)
    );

    // --------------------
    // Range to index expansion
    // --------------------

    csr_index_generator u_generator (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .not_empty                  (not_empty),
        .head_data                  (head_data),
        .index_ready                (index_ready),
        .pop                        (pop),
        .index_valid                (index_valid),
        .index_out                  (index_out),
        .index_last                 (index_last)
    );

endmodule : csr_index_top

/* tb/tb_csr_index_top.sv */
`include "csr_index_settings.svh"

module tb_csr_index_top;

    import csr_index_pkg::*;

    localparam int module_id   = 2;
    localparam int num_entries = 35;
    localparam csr_module_mask_t lane_mask = csr_module_mask_t'(1 << module_id);

    // Table phases: single range, filtering, random sink, burst
    localparam int single_end = 1;
    localparam int filter_end = 7;
    localparam int random_end = 15;

    logic             ap_clk;
    logic             areset_csr_index_generator;
    logic             response_valid;
    csr_module_mask_t response_destination;
    csr_index_t       response_offset;
    csr_degree_t      response_degree;
    logic             response_ready;
    logic             index_valid;
    csr_index_t       index_out;
    logic             index_last;
    logic             index_ready;

    // Stimulus table
    csr_module_mask_t tbl_dest   [num_entries];
    csr_index_t       tbl_offset [num_entries];
    csr_degree_t      tbl_degree [num_entries];

    // Expected stream, in table order
    csr_index_t exp_index_q [$];
    logic       exp_last_q  [$];

    logic        table_ready;
    int          total_expected;
    int          received_count;
    // Sink mode: 0 random, 1 stalled, 2 always ready
    int          ready_mode;
    logic [31:0] lcg_state;
    // Response ready as seen in the previous cycle
    logic        ready_seen;
    // Stall tracking for the stability check
    logic        stall_q;
    csr_index_t  held_index;
    logic        held_last;

    csr_index_top #(
        .module_id (module_id)
    ) UUT (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_destination       (response_destination),
        .response_offset            (response_offset),
        .response_degree            (response_degree),
        .response_ready             (response_ready),
        .index_valid                (index_valid),
        .index_out                  (index_out),
        .index_last                 (index_last),
        .index_ready                (index_ready)
    );

    always #2 ap_clk = ~ap_clk;

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic set_entry(input int i, input csr_module_mask_t dest,
                             input csr_index_t offset, input csr_degree_t degree);
        tbl_dest[i]   = dest;
        tbl_offset[i] = offset;
        tbl_degree[i] = degree;
    endtask

    task automatic build_table();
        set_entry(0, 8'h04, 32'd100, 32'd3);
        // Foreign lane, multi-bit, zero degree and empty masks mixed in
        set_entry(1, 8'h01, 32'd200, 32'd5);
        set_entry(2, 8'h06, 32'd300, 32'd4);
        set_entry(3, 8'h04, 32'd400, 32'd0);
        set_entry(4, 8'h04, 32'd500, 32'd2);
        set_entry(5, 8'h00, 32'd600, 32'd3);
        set_entry(6, 8'h04, 32'd700, 32'd1);
        // Random sink phase
        set_entry(7, 8'h04, 32'd2000, 32'd4);
        set_entry(8, 8'h04, 32'd2100, 32'd1);
        set_entry(9, 8'h10, 32'd2200, 32'd3);
        set_entry(10, 8'h04, 32'd2300, 32'd7);
        set_entry(11, 8'h04, 32'd2400, 32'd0);
        set_entry(12, 8'h04, 32'd2500, 32'd5);
        set_entry(13, 8'h05, 32'd2600, 32'd2);
        set_entry(14, 8'h04, 32'hffff_fff0, 32'd3);
        // Burst, more ranges than the FIFO holds
        for (int i = random_end; i < num_entries; i++) begin
            set_entry(i, 8'h04, 32'd4000 + 32'(16 * i), 32'd2);
        end
    endtask

    // Only this lane's ranges with edges count
    function automatic bit entry_counts(input int i);
        return (tbl_dest[i] == lane_mask) && (tbl_degree[i] != '0);
    endfunction

    function automatic int count_expected(input int first, input int last);
        int total;
        total = 0;
        for (int i = first; i < last; i++) begin
            if (entry_counts(i)) begin
                total += int'(tbl_degree[i]);
            end
        end
        return total;
    endfunction

    task automatic build_expected();
        for (int i = 0; i < num_entries; i++) begin
            if (entry_counts(i)) begin
                for (int k = 0; k < int'(tbl_degree[i]); k++) begin
                    exp_index_q.push_back(tbl_offset[i] + csr_index_t'(k));
                    exp_last_q.push_back(k == int'(tbl_degree[i]) - 1);
                end
            end
        end
        total_expected = exp_index_q.size();
    endtask

    // Presents table entries, valid only after a ready cycle
    task automatic send_entries(input int first, input int last);
        int idx;
        idx = first;
        while (idx < last) begin
            @(negedge ap_clk);
            if (ready_seen) begin
                response_valid       = 1'b1;
                response_destination = tbl_dest[idx];
                response_offset      = tbl_offset[idx];
                response_degree      = tbl_degree[idx];
                idx++;
            end else begin
                response_valid = 1'b0;
            end
        end
        @(negedge ap_clk);
        response_valid = 1'b0;
    endtask

    // Waits for a running total, then idles to catch extra indices
    task automatic drain_and_count(input int expected_total);
        while (received_count < expected_total) begin
            @(negedge ap_clk);
        end
        repeat (12) @(negedge ap_clk);
        check_value("received_count", received_count, expected_total);
    endtask

    task automatic check_idle_outputs();
        check_value("index_valid", index_valid, 1'b0);
        check_value("index_last", index_last, 1'b0);
        check_value("response_ready", response_ready, 1'b1);
    endtask

    // --------------------
    // Sink and monitor
    // --------------------

    always @(negedge ap_clk) begin
        lcg_state = lcg_next(lcg_state);
        case (ready_mode)
            0:       index_ready = lcg_state[31];
            1:       index_ready = 1'b0;
            default: index_ready = 1'b1;
        endcase
    end

    always @(posedge ap_clk) begin
        ready_seen <= response_ready;
    end

    always @(posedge ap_clk) begin
        if (!areset_csr_index_generator) begin
            // Stalled beat must not move
            if (stall_q) begin
                check_value("index_valid", index_valid, 1'b1);
                check_value("index_out", index_out, held_index);
                check_value("index_last", index_last, held_last);
            end
            if (index_valid && index_ready) begin
                if (exp_index_q.size() == 0) begin
                    fail_run("An index arrived that no range should have produced");
                end
                check_value("index_out", index_out, exp_index_q.pop_front());
                check_value("index_last", index_last, exp_last_q.pop_front());
                received_count++;
            end
            stall_q    = index_valid && !index_ready;
            held_index = index_out;
            held_last  = index_last;
        end
    end

    // Watchdog scaled to the table size
    initial begin
        int limit_cycles;
        wait (table_ready);
        limit_cycles = 20 * num_entries + 4 * total_expected + 100;
        repeat (limit_cycles) @(posedge ap_clk);
        fail_run("Timeout: the index stream did not complete in time");
    end

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        int waited;
        ap_clk                     = 1'b0;
        areset_csr_index_generator = 1'b1;
        response_valid             = 1'b0;
        response_destination       = '0;
        response_offset            = '0;
        response_degree            = '0;
        index_ready                = 1'b0;
        ready_mode                 = 2;
        lcg_state                  = 32'hde2d_8f7f;
        received_count             = 0;
        stall_q                    = 1'b0;
        held_index                 = '0;
        held_last                  = 1'b0;
        table_ready                = 1'b0;
        build_table();
        build_expected();
        table_ready = 1'b1;

        repeat (4) begin
            @(negedge ap_clk);
            check_idle_outputs();
        end
        areset_csr_index_generator = 1'b0;
        repeat (3) begin
            @(negedge ap_clk);
            check_idle_outputs();
        end

        // Single range, then filtered and zero-degree entries
        send_entries(0, single_end);
        drain_and_count(count_expected(0, single_end));
        send_entries(single_end, filter_end);
        drain_and_count(count_expected(0, filter_end));

        @(posedge ap_clk);
        ready_mode = 0;
        send_entries(filter_end, random_end);
        drain_and_count(count_expected(0, random_end));

        // Burst into a stalled sink until the input ready drops
        @(posedge ap_clk);
        ready_mode = 1;
        fork
            send_entries(random_end, num_entries);
            begin
                waited = 0;
                while (response_ready && waited < 4 * (num_entries - random_end) + 20) begin
                    @(negedge ap_clk);
                    waited++;
                end
                if (response_ready) begin
                    fail_run("response_ready never fell while the sink was stalled");
                end
                repeat (8) @(negedge ap_clk);
                @(posedge ap_clk);
                ready_mode = 2;
            end
        join
        drain_and_count(total_expected);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : tb_csr_index_top

/* filelist.f */
+incdir+include
src/csr_index_pkg.sv
src/csr_index_configure_engine.sv
src/csr_index_config_fifo.sv
src/csr_index_generator.sv
src/csr_index_top.sv
tb/tb_csr_index_top.sv

/* Bender.yml */
package:
  name: csr_index

export_include_dirs:
  - include

sources:
  - files:
      - src/csr_index_pkg.sv
      - src/csr_index_configure_engine.sv
      - src/csr_index_config_fifo.sv
      - src/csr_index_generator.sv
      - src/csr_index_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_csr_index_top.sv
